// ==== Bender.yml ====
package:
  name: dcache

sources:
  - src/dcache_cfg_pkg.sv
  - src/dcache_bus_pkg.sv
  - src/dcache_req_decode.sv
  - src/dcache_store.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - bench/dcache_mem_model.sv
      - bench/dcache_tb.sv

// ==== bench/dcache_mem_model.sv ====
/*
 * Behavioural memory behind the cache's write-buffer and read-arbiter ports.
 * Unwritten words read as their word address XOR 32'h5a5a0000. Written words
 * are kept in a small log, and word_at gives the testbench any word.
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_model #(
	parameter int LINE_WORDS = 4,
	parameter int MAX_WORDS = 256
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic wr_req,
	input wire dcache_bus_pkg::mem_wr_t wr,
	output logic wr_ready,
	input wire logic rd_req,
	input wire dcache_bus_pkg::mem_rd_t rd,
	output logic [31:0] rd_data,
	output logic rd_valid,
	output logic rd_last,
	output int rd_count
);

	logic [31:0] log_addr [MAX_WORDS];
	logic [31:0] log_data [MAX_WORDS];
	int log_used = 0;
	logic busy;
	int delay;
	logic [31:0] base;
	logic [7:0] len;
	logic [7:0] beat;
	logic [7:0] next_beat;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [31:0] value;
		value = {2'b00, addr[31:2]} ^ 32'h5a5a0000;
		for (int i = 0; i < log_used; i++) begin
			if (log_addr[i] == {addr[31:2], 2'b00}) begin
				value = log_data[i];
			end
		end
		return value;
	endfunction

	task automatic put_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] merged;
		int slot;
		merged = word_at(addr);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = data[8*b +: 8];
			end
		end
		slot = log_used;
		for (int i = 0; i < log_used; i++) begin
			if (log_addr[i] == {addr[31:2], 2'b00}) begin
				slot = i;
			end
		end
		log_addr[slot] = {addr[31:2], 2'b00};
		log_data[slot] = merged;
		if (slot == log_used) begin
			log_used++;
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			wr_ready <= 1'b0;
			rd_valid <= 1'b0;
			rd_last <= 1'b0;
			rd_data <= '0;
			rd_count <= 0;
			busy <= 1'b0;
		end else begin
			// about one cycle in four stalls the write buffer
			wr_ready <= ($urandom % 4) != 0;
			if (wr_req) begin
				if (wr.wtype == dcache_bus_pkg::WR_LINE) begin
					for (int i = 0; i < LINE_WORDS; i++) begin
						put_word(wr.addr + 32'(4 * i), wr.data[32*i +: 32], 4'hf);
					end
				end else begin
					put_word(wr.addr, wr.data[31:0], wr.strb);
				end
			end
			// a beat on rd_valid is taken by the cache on this edge
			next_beat = rd_valid ? beat + 8'd1 : beat;
			if (rd_valid && rd_last) begin
				rd_valid <= 1'b0;
				rd_last <= 1'b0;
				busy <= 1'b0;
			end else if (rd_valid || (busy && delay == 0)) begin
				rd_valid <= 1'b1;
				rd_last <= (next_beat == len);
				rd_data <= word_at(base + 32'(next_beat) * 32'd4);
				beat <= next_beat;
			end else if (busy) begin
				delay <= delay - 1;
			end else if (rd_req) begin
				busy <= 1'b1;
				rd_count <= rd_count + 1;
				base <= {rd.addr[31:2], 2'b00};
				len <= rd.len;
				beat <= 8'd0;
				delay <= int'($urandom % 4);
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/dcache_tb.sv ====
/*
 * Testbench for the data cache. Applies a table of core requests to the
 * cache in front of a behavioural memory and compares read data, memory
 * words, read-request counts and hit latency with the memory pattern rule.
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int ROW_CYCLES = 200;
	localparam int MAX_ROWS = 48;
	// sampling edge plus the check cycle
	localparam int HIT_LATENCY = 2;

	localparam logic [31:0] ADDR_X = 32'h0000_0120;
	localparam logic [31:0] ADDR_Y = 32'h0000_0234;
	// same set, three tags
	localparam logic [31:0] ADDR_A = 32'h0000_1050;
	localparam logic [31:0] ADDR_B = 32'h0000_2050;
	localparam logic [31:0] ADDR_C = 32'h0000_3050;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_FENCE,
		OP_MEM
	} op_e;

	typedef struct packed {
		op_e op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
		logic [31:0] expect_data;
		logic expect_rd;
		logic fast;
		logic victim;
	} row_t;

	logic clock;
	logic reset;
	logic core_sel;
	logic core_fence;
	logic core_ready;
	dcache_bus_pkg::core_req_t core_req;
	logic [31:0] core_rdata;
	logic wr_req;
	logic wr_ready;
	dcache_bus_pkg::mem_wr_t wr;
	logic rd_req;
	dcache_bus_pkg::mem_rd_t rd;
	logic [31:0] rd_data;
	logic rd_valid;
	logic rd_last;
	int rd_count;

	row_t rows [MAX_ROWS];
	int n_rows = 0;
	int cycles = 0;
	int edge_count = 0;

	dcache_top u_dut (
		.clock, .reset, .core_sel, .core_req, .core_fence, .core_ready, .core_rdata,
		.wr_req, .wr, .wr_ready, .rd_req, .rd, .rd_data, .rd_valid, .rd_last
	);

	dcache_mem_model #(.LINE_WORDS(1 << (dcache_cfg_pkg::DEF_OFFSET_W - 2))) u_mem (
		.clock, .reset, .wr_req, .wr, .wr_ready, .rd_req, .rd, .rd_data, .rd_valid,
		.rd_last, .rd_count
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clock = ~clock;
		end
	end

	// edge_count runs with the cache's victim flip bit
	always @(posedge clock) begin
		cycles <= cycles + 1;
		edge_count <= reset ? 0 : edge_count + 1;
		if (cycles > ROW_CYCLES * (n_rows + 1)) begin
			$display("timeout: the cache gave no ready within %0d cycles", cycles);
			$display("Regression failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	function automatic logic [31:0] pattern_word(input logic [31:0] addr);
		return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] value;
		value = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				value[8*b +: 8] = data[8*b +: 8];
			end
		end
		return value;
	endfunction

	task automatic check_rdata(input logic [dcache_cfg_pkg::DATA_W-1:0] got,
		input logic [dcache_cfg_pkg::DATA_W-1:0] want, input int row);
		if (got !== want) begin
			$display("MISMATCH at %0t: row %0d read data %h, expected %h", $time, row, got, want);
			$display("Regression failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_mem_word(input logic [dcache_cfg_pkg::DATA_W-1:0] got,
		input logic [dcache_cfg_pkg::DATA_W-1:0] want, input int row);
		if (got !== want) begin
			$display("MISMATCH at %0t: row %0d memory word %h, expected %h", $time, row, got, want);
			$display("Regression failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_rd_count(input int got, input int want, input int row);
		if (got != want) begin
			$display("MISMATCH at %0t: row %0d read requests %0d, expected %0d",
				$time, row, got, want);
			$display("Regression failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_latency(input int got, input int want, input int row);
		if (got != want) begin
			$display("MISMATCH at %0t: row %0d ready after %0d cycles, expected %0d",
				$time, row, got, want);
			$display("Regression failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] strb, input logic [31:0] want, input logic expect_rd,
		input logic fast, input logic victim);
		rows[n_rows] = '{op, addr, wdata, strb, want, expect_rd, fast, victim};
		n_rows++;
	endtask

	task automatic build_table();
		logic [31:0] x8;
		logic [31:0] y0;
		logic [31:0] uart;
		logic [31:0] spi;
		logic [31:0] gpio;
		logic [31:0] clint;
		x8 = merge_bytes(pattern_word(ADDR_X + 8), 32'hdead_beef, 4'b0110);
		y0 = merge_bytes(pattern_word(ADDR_Y), 32'h1234_5678, 4'b1001);
		uart = merge_bytes(pattern_word(dcache_cfg_pkg::DEV_UART_LO), 32'h5566_7788, 4'b0001);
		spi = merge_bytes(pattern_word(dcache_cfg_pkg::DEV_SPI_LO), 32'h0a0b_0c0d, 4'b0011);
		gpio = merge_bytes(pattern_word(dcache_cfg_pkg::DEV_GPIO_LO), 32'h8765_4321, 4'hf);
		clint = merge_bytes(pattern_word(dcache_cfg_pkg::DEV_CLINT_LO), 32'h1111_2222, 4'b1100);
		// read miss, then hits in the same line
		add_row(OP_READ, ADDR_X, '0, '0, pattern_word(ADDR_X), 1'b1, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_X + 4, '0, '0, pattern_word(ADDR_X + 4), 1'b0, 1'b1, 1'b0);
		// partial store hit, then store miss with allocate
		add_row(OP_WRITE, ADDR_X + 8, 32'hdead_beef, 4'b0110, '0, 1'b0, 1'b1, 1'b0);
		add_row(OP_READ, ADDR_X + 8, '0, '0, x8, 1'b0, 1'b1, 1'b0);
		add_row(OP_WRITE, ADDR_Y, 32'h1234_5678, 4'b1001, '0, 1'b1, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_Y, '0, '0, y0, 1'b0, 1'b1, 1'b0);
		add_row(OP_READ, ADDR_Y + 4, '0, '0, pattern_word(ADDR_Y + 4), 1'b0, 1'b1, 1'b0);
		// A dirty in way 0, B into way 1, C evicts A
		add_row(OP_WRITE, ADDR_A, 32'hcafe_f00d, 4'hf, '0, 1'b1, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_B, '0, '0, pattern_word(ADDR_B), 1'b1, 1'b0, 1'b1);
		add_row(OP_READ, ADDR_C, '0, '0, pattern_word(ADDR_C), 1'b1, 1'b0, 1'b0);
		add_row(OP_MEM, ADDR_A, '0, '0, 32'hcafe_f00d, 1'b0, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_A, '0, '0, 32'hcafe_f00d, 1'b1, 1'b0, 1'b1);
		// device windows bypass the cache
		add_row(OP_READ, dcache_cfg_pkg::DEV_UART_LO, '0, '0,
			pattern_word(dcache_cfg_pkg::DEV_UART_LO), 1'b1, 1'b0, 1'b0);
		add_row(OP_READ, dcache_cfg_pkg::DEV_UART_LO, '0, '0,
			pattern_word(dcache_cfg_pkg::DEV_UART_LO), 1'b1, 1'b0, 1'b0);
		add_row(OP_WRITE, dcache_cfg_pkg::DEV_UART_LO, 32'h5566_7788, 4'b0001, '0,
			1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, dcache_cfg_pkg::DEV_UART_LO, '0, '0, uart, 1'b0, 1'b0, 1'b0);
		add_row(OP_WRITE, dcache_cfg_pkg::DEV_SPI_LO, 32'h0a0b_0c0d, 4'b0011, '0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, dcache_cfg_pkg::DEV_SPI_LO, '0, '0, spi, 1'b0, 1'b0, 1'b0);
		// next word up stays untouched
		add_row(OP_MEM, dcache_cfg_pkg::DEV_SPI_LO + 4, '0, '0,
			pattern_word(dcache_cfg_pkg::DEV_SPI_LO + 4), 1'b0, 1'b0, 1'b0);
		add_row(OP_READ, dcache_cfg_pkg::DEV_SPI_LO, '0, '0, spi, 1'b1, 1'b0, 1'b0);
		add_row(OP_WRITE, dcache_cfg_pkg::DEV_GPIO_LO, 32'h8765_4321, 4'hf, '0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, dcache_cfg_pkg::DEV_GPIO_LO, '0, '0, gpio, 1'b0, 1'b0, 1'b0);
		add_row(OP_READ, dcache_cfg_pkg::DEV_GPIO_LO, '0, '0, gpio, 1'b1, 1'b0, 1'b0);
		add_row(OP_WRITE, dcache_cfg_pkg::DEV_CLINT_LO, 32'h1111_2222, 4'b1100, '0,
			1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, dcache_cfg_pkg::DEV_CLINT_LO, '0, '0, clint, 1'b0, 1'b0, 1'b0);
		add_row(OP_READ, dcache_cfg_pkg::DEV_CLINT_LO, '0, '0, clint, 1'b1, 1'b0, 1'b0);
		// one more dirty word, then fence and check memory
		add_row(OP_WRITE, ADDR_A + 4, 32'h0f0f_0f0f, 4'hf, '0, 1'b0, 1'b1, 1'b0);
		add_row(OP_FENCE, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, ADDR_X + 8, '0, '0, x8, 1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, ADDR_Y, '0, '0, y0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, ADDR_A + 4, '0, '0, 32'h0f0f_0f0f, 1'b0, 1'b0, 1'b0);
		add_row(OP_MEM, ADDR_X, '0, '0, pattern_word(ADDR_X), 1'b0, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_X + 8, '0, '0, x8, 1'b1, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_Y, '0, '0, y0, 1'b1, 1'b0, 1'b0);
		add_row(OP_READ, ADDR_A + 4, '0, '0, 32'h0f0f_0f0f, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic run_row(input int i);
		row_t r;
		int reads_before;
		int start;
		r = rows[i];
		@(posedge clock);
		#DRIVE_DELAY;
		if (r.op == OP_MEM) begin
			check_mem_word(u_mem.word_at(r.addr), r.expect_data, i);
		end else begin
			// victim way is the flip bit two edges on, so start on the right parity
			if (edge_count[0] != r.victim) begin
				@(posedge clock);
				#DRIVE_DELAY;
			end
			reads_before = rd_count;
			start = edge_count;
			core_req.addr = r.addr;
			core_req.wdata = r.wdata;
			core_req.strb = r.strb;
			core_req.size = dcache_cfg_pkg::SIZE_WORD;
			core_req.write = (r.op == OP_WRITE);
			if (r.op == OP_FENCE) begin
				core_fence = 1'b1;
			end else begin
				core_sel = 1'b1;
			end
			@(negedge clock);
			while (!core_ready) begin
				@(negedge clock);
			end
			if (r.op == OP_READ) begin
				check_rdata(core_rdata, r.expect_data, i);
			end
			if (r.fast) begin
				check_latency(edge_count - start, HIT_LATENCY, i);
			end
			@(posedge clock);
			#DRIVE_DELAY;
			core_sel = 1'b0;
			core_fence = 1'b0;
			check_rd_count(rd_count - reads_before, int'(r.expect_rd), i);
		end
	endtask

	initial begin
		void'($urandom(32'h1bcf));
		reset = 1'b1;
		core_sel = 1'b0;
		core_fence = 1'b0;
		core_req = '0;
		build_table();
		repeat (3) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			run_row(i);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
src/dcache_cfg_pkg.sv
src/dcache_bus_pkg.sv
src/dcache_req_decode.sv
src/dcache_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

// ==== src/dcache_bus_pkg.sv ====
/*
 * Packed structs and enums shared by the data cache stages and the memory model.
 * Covers the core request, both memory-side ports and the lookup result.
 */
`default_nettype none

package dcache_bus_pkg;

	typedef struct packed {
		logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
		logic [dcache_cfg_pkg::DATA_W-1:0] wdata;
		logic [3:0] strb;
		logic [2:0] size;
		logic write;
	} core_req_t;

	// encoding as seen by the write buffer
	typedef enum logic [2:0] {
		WR_BYTE = 3'b000,
		WR_HALF = 3'b001,
		WR_WORD = 3'b010,
		WR_LINE = 3'b100
	} wr_type_e;

	typedef struct packed {
		logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
		logic [dcache_cfg_pkg::MAX_LINE_W-1:0] data;
		logic [3:0] strb;
		wr_type_e wtype;
	} mem_wr_t;

	typedef struct packed {
		logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
		logic [2:0] size;
		logic [7:0] len;
	} mem_rd_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CHECK,
		ST_MISS,
		ST_REPLACE,
		ST_LOAD,
		ST_FENCE,
		ST_FLUSH_NEXT
	} cache_state_e;

	// tag and line are right-aligned, upper bits zero
	typedef struct packed {
		logic hit;
		logic hit_way;
		logic [dcache_cfg_pkg::DATA_W-1:0] hit_word;
		logic victim_dirty;
		logic [dcache_cfg_pkg::ADDR_W-1:0] victim_tag;
		logic [dcache_cfg_pkg::MAX_LINE_W-1:0] victim_line;
		logic any_dirty;
	} lookup_t;

endpackage

`default_nettype wire

// ==== src/dcache_cfg_pkg.sv ====
/*
 * Data cache geometry defaults, device address windows and bus size codes.
 * Referenced by scoped name from the cache RTL and from the testbench.
 */
`default_nettype none

package dcache_cfg_pkg;

	parameter int ADDR_W = 32;
	parameter int DATA_W = 32;

	// 16 sets of 16-byte lines by default
	parameter int DEF_INDEX_W = 4;
	parameter int DEF_OFFSET_W = 4;

	// widest line a memory-side transfer carries
	parameter int MAX_LINE_W = 128;

	// device windows, one word each, never cached
	parameter logic [ADDR_W-1:0] DEV_UART_LO = 32'h1000_0000;
	parameter logic [ADDR_W-1:0] DEV_UART_HI = 32'h1000_0003;
	parameter logic [ADDR_W-1:0] DEV_SPI_LO = 32'h1000_1000;
	parameter logic [ADDR_W-1:0] DEV_SPI_HI = 32'h1000_1003;
	parameter logic [ADDR_W-1:0] DEV_GPIO_LO = 32'h1000_2000;
	parameter logic [ADDR_W-1:0] DEV_GPIO_HI = 32'h1000_2003;
	parameter logic [ADDR_W-1:0] DEV_CLINT_LO = 32'h0200_0000;
	parameter logic [ADDR_W-1:0] DEV_CLINT_HI = 32'h0200_0003;

	parameter logic [2:0] SIZE_WORD = 3'b010;

endpackage

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
/*
 * Third cache stage. Miss and fence FSM, victim choice, write-back through
 * the write buffer and burst refill through the read arbiter. Drives the
 * ready pulse and read data back to the core.
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl #(
	parameter int INDEX_W = dcache_cfg_pkg::DEF_INDEX_W,
	parameter int OFFSET_W = dcache_cfg_pkg::DEF_OFFSET_W
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic started,
	input wire logic fence,
	input wire dcache_bus_pkg::core_req_t cur,
	input wire logic [dcache_cfg_pkg::ADDR_W-INDEX_W-OFFSET_W-1:0] tag,
	input wire logic [INDEX_W-1:0] index,
	input wire logic [OFFSET_W-1:0] offset,
	input wire logic uncached,
	input wire dcache_bus_pkg::lookup_t look,
	input wire logic wr_ready,
	input wire logic [31:0] rd_data,
	input wire logic rd_valid,
	input wire logic rd_last,
	output logic accept,
	output logic ready,
	output logic [31:0] rdata,
	output logic hit_write,
	output logic fill,
	output logic fill_way,
	output logic [(8 << OFFSET_W)-1:0] fill_line,
	output logic fill_dirty,
	output logic invalidate_all,
	output logic walk,
	output logic [INDEX_W-1:0] walk_index,
	output logic wr_req,
	output dcache_bus_pkg::mem_wr_t wr,
	output logic rd_req,
	output dcache_bus_pkg::mem_rd_t rd
);

	localparam int TAG_W = dcache_cfg_pkg::ADDR_W - INDEX_W - OFFSET_W;
	localparam int LINE_W = 8 << OFFSET_W;
	localparam int WORDS = LINE_W / 32;

	dcache_bus_pkg::cache_state_e state_q, state_d;
	logic flip_q;
	logic victim_q;
	logic fence_q;
	logic done_q;
	logic [INDEX_W:0] walk_q;
	logic walk_last;
	logic last_beat;
	logic [LINE_W-1:0] refill_q;
	logic [LINE_W-1:0] new_line;
	logic [LINE_W-1:0] merged_line;
	logic [31:0] rdata_q;
	logic [OFFSET_W-3:0] word_sel;
	logic [INDEX_W-1:0] vic_index;

	assign word_sel = offset[OFFSET_W-1:2];
	// walk_q is {set, way}
	assign walk_index = walk_q[INDEX_W:1];
	assign walk_last = &walk_q;
	assign walk = fence_q;
	assign fill_way = fence_q ? walk_q[0] : victim_q;
	assign vic_index = fence_q ? walk_index : index;
	assign last_beat = (state_q == dcache_bus_pkg::ST_LOAD) && rd_valid && rd_last;

	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_bus_pkg::ST_IDLE: begin
				if (started) begin
					state_d = dcache_bus_pkg::ST_CHECK;
				end else if (fence) begin
					state_d = dcache_bus_pkg::ST_FENCE;
				end
			end
			dcache_bus_pkg::ST_CHECK: begin
				if (uncached || !look.hit) begin
					state_d = dcache_bus_pkg::ST_MISS;
				end else begin
					state_d = dcache_bus_pkg::ST_IDLE;
				end
			end
			dcache_bus_pkg::ST_MISS: begin
				if (wr_ready) begin
					if (fence_q || (uncached && cur.write) || (!uncached && look.victim_dirty)) begin
						state_d = dcache_bus_pkg::ST_REPLACE;
					end else begin
						state_d = dcache_bus_pkg::ST_LOAD;
					end
				end
			end
			dcache_bus_pkg::ST_REPLACE: begin
				if (fence_q) begin
					state_d = dcache_bus_pkg::ST_FLUSH_NEXT;
				end else if (uncached) begin
					state_d = dcache_bus_pkg::ST_IDLE;
				end else begin
					state_d = dcache_bus_pkg::ST_LOAD;
				end
			end
			dcache_bus_pkg::ST_LOAD: begin
				if (rd_valid && rd_last) begin
					state_d = dcache_bus_pkg::ST_IDLE;
				end
			end
			dcache_bus_pkg::ST_FENCE: begin
				// clean entries skip straight to the next one
				if (look.victim_dirty) begin
					state_d = dcache_bus_pkg::ST_MISS;
				end else begin
					state_d = dcache_bus_pkg::ST_FLUSH_NEXT;
				end
			end
			dcache_bus_pkg::ST_FLUSH_NEXT: begin
				state_d = walk_last ? dcache_bus_pkg::ST_IDLE : dcache_bus_pkg::ST_FENCE;
			end
			default: begin
				state_d = dcache_bus_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= dcache_bus_pkg::ST_IDLE;
			flip_q <= 1'b0;
			fence_q <= 1'b0;
			done_q <= 1'b0;
			walk_q <= '0;
		end else begin
			state_q <= state_d;
			flip_q <= ~flip_q;
			done_q <= last_beat;
			if (state_q == dcache_bus_pkg::ST_IDLE && state_d == dcache_bus_pkg::ST_FENCE) begin
				fence_q <= 1'b1;
				walk_q <= '0;
			end else if (state_q == dcache_bus_pkg::ST_FENCE && !look.any_dirty) begin
				// nothing to write back, finish on this step
				walk_q <= '1;
			end else if (state_q == dcache_bus_pkg::ST_FLUSH_NEXT) begin
				walk_q <= walk_q + 1'b1;
				fence_q <= !walk_last;
			end
		end
	end

	// victim way frozen for the whole miss
	always_ff @(posedge clock) begin
		if (state_q == dcache_bus_pkg::ST_CHECK && state_d == dcache_bus_pkg::ST_MISS) begin
			victim_q <= flip_q;
		end
	end

	// burst words arrive lowest first and shift down from the top
	always_comb begin
		new_line = {rd_data, refill_q[LINE_W-1:32]};
		merged_line = new_line;
		for (int b = 0; b < 4; b++) begin
			if (cur.strb[b]) begin
				merged_line[word_sel*32 + 8*b +: 8] = cur.wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == dcache_bus_pkg::ST_LOAD && rd_valid) begin
			refill_q <= new_line;
		end
		if (last_beat) begin
			rdata_q <= uncached ? rd_data : new_line[word_sel*32 +: 32];
		end
	end

	assign accept = (state_q == dcache_bus_pkg::ST_IDLE) && !done_q;
	assign hit_write = (state_q == dcache_bus_pkg::ST_CHECK) && look.hit && !uncached && cur.write;
	assign fill = last_beat && !uncached;
	assign fill_line = cur.write ? merged_line : new_line;
	assign fill_dirty = cur.write;
	assign invalidate_all = (state_q == dcache_bus_pkg::ST_FLUSH_NEXT) && walk_last;

	assign ready = done_q || invalidate_all ||
		((state_q == dcache_bus_pkg::ST_CHECK) && look.hit && !uncached) ||
		((state_q == dcache_bus_pkg::ST_REPLACE) && uncached && !fence_q);
	assign rdata = done_q ? rdata_q : look.hit_word;

	assign wr_req = (state_q == dcache_bus_pkg::ST_REPLACE);
	assign rd_req = (state_q == dcache_bus_pkg::ST_LOAD);

	always_comb begin
		wr = '0;
		if (uncached && !fence_q) begin
			wr.addr = cur.addr;
			wr.data[31:0] = cur.wdata;
			wr.strb = cur.strb;
			case (cur.size[1:0])
				2'b00: wr.wtype = dcache_bus_pkg::WR_BYTE;
				2'b01: wr.wtype = dcache_bus_pkg::WR_HALF;
				default: wr.wtype = dcache_bus_pkg::WR_WORD;
			endcase
		end else begin
			wr.addr = {look.victim_tag[TAG_W-1:0], vic_index, {OFFSET_W{1'b0}}};
			wr.data = look.victim_line;
			wr.strb = 4'hf;
			wr.wtype = dcache_bus_pkg::WR_LINE;
		end
	end

	always_comb begin
		if (uncached) begin
			rd.addr = cur.addr;
			rd.size = cur.size;
			rd.len = 8'd0;
		end else begin
			rd.addr = {tag, index, {OFFSET_W{1'b0}}};
			rd.size = dcache_cfg_pkg::SIZE_WORD;
			rd.len = 8'(WORDS - 1);
		end
	end

endmodule

`default_nettype wire

// ==== src/dcache_req_decode.sv ====
/*
 * First cache stage. Registers the core request while the controller accepts,
 * pulses started, and splits the held address into tag, index and offset.
 * Device windows are flagged as uncached here.
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_req_decode #(
	parameter int INDEX_W = dcache_cfg_pkg::DEF_INDEX_W,
	parameter int OFFSET_W = dcache_cfg_pkg::DEF_OFFSET_W
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic sel,
	input wire dcache_bus_pkg::core_req_t req,
	input wire logic accept,
	output dcache_bus_pkg::core_req_t cur,
	output logic [dcache_cfg_pkg::ADDR_W-INDEX_W-OFFSET_W-1:0] tag,
	output logic [INDEX_W-1:0] index,
	output logic [OFFSET_W-1:0] offset,
	output logic uncached,
	output logic started
);

	logic take;

	// started blocks a second capture of the same held request
	assign take = sel && accept && !started;

	always_ff @(posedge clock) begin
		if (reset) begin
			started <= 1'b0;
		end else begin
			started <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			cur <= req;
		end
	end

	assign {tag, index, offset} = cur.addr;

	assign uncached =
		(cur.addr >= dcache_cfg_pkg::DEV_UART_LO && cur.addr <= dcache_cfg_pkg::DEV_UART_HI) ||
		(cur.addr >= dcache_cfg_pkg::DEV_SPI_LO && cur.addr <= dcache_cfg_pkg::DEV_SPI_HI) ||
		(cur.addr >= dcache_cfg_pkg::DEV_GPIO_LO && cur.addr <= dcache_cfg_pkg::DEV_GPIO_HI) ||
		(cur.addr >= dcache_cfg_pkg::DEV_CLINT_LO && cur.addr <= dcache_cfg_pkg::DEV_CLINT_HI);

endmodule

`default_nettype wire

// ==== src/dcache_store.sv ====
/*
 * Second cache stage. Two-way tag, valid, dirty and line arrays with a
 * combinational lookup. Takes hit writes, line fills and a full invalidate
 * from the controller; fill_way also picks the way reported as victim.
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_store #(
	parameter int INDEX_W = dcache_cfg_pkg::DEF_INDEX_W,
	parameter int OFFSET_W = dcache_cfg_pkg::DEF_OFFSET_W
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [dcache_cfg_pkg::ADDR_W-INDEX_W-OFFSET_W-1:0] tag,
	input wire logic [INDEX_W-1:0] index,
	input wire logic [OFFSET_W-1:0] offset,
	input wire dcache_bus_pkg::core_req_t cur,
	input wire logic hit_write,
	input wire logic fill,
	input wire logic fill_way,
	input wire logic [(8 << OFFSET_W)-1:0] fill_line,
	input wire logic fill_dirty,
	input wire logic invalidate_all,
	input wire logic [INDEX_W-1:0] walk_index,
	input wire logic walk,
	output dcache_bus_pkg::lookup_t look
);

	localparam int TAG_W = dcache_cfg_pkg::ADDR_W - INDEX_W - OFFSET_W;
	localparam int SETS = 1 << INDEX_W;
	localparam int LINE_W = 8 << OFFSET_W;

	logic [TAG_W-1:0] tag_mem [2][SETS];
	logic [LINE_W-1:0] line_mem [2][SETS];
	logic [1:0][SETS-1:0] valid_q;
	logic [1:0][SETS-1:0] dirty_q;

	logic [1:0] way_hit;
	logic hit_way;
	logic [LINE_W-1:0] hit_line;
	logic [31:0] hit_word;
	logic [31:0] merged_word;
	logic [OFFSET_W-3:0] word_sel;
	logic [INDEX_W-1:0] vic_index;

	assign word_sel = offset[OFFSET_W-1:2];
	assign vic_index = walk ? walk_index : index;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
		end
	end

	assign hit_way = way_hit[1];
	assign hit_line = line_mem[hit_way][index];
	assign hit_word = hit_line[word_sel*32 +: 32];

	// strobed bytes from the core over the cached word
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			merged_word[8*b +: 8] = cur.strb[b] ? cur.wdata[8*b +: 8] : hit_word[8*b +: 8];
		end
	end

	always_comb begin
		look = '0;
		look.hit = |way_hit;
		look.hit_way = hit_way;
		look.hit_word = hit_word;
		look.victim_dirty = dirty_q[fill_way][vic_index];
		look.victim_tag[TAG_W-1:0] = tag_mem[fill_way][vic_index];
		look.victim_line[LINE_W-1:0] = line_mem[fill_way][vic_index];
		look.any_dirty = |dirty_q;
	end

	always_ff @(posedge clock) begin
		if (reset || invalidate_all) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill) begin
			valid_q[fill_way][index] <= 1'b1;
			dirty_q[fill_way][index] <= fill_dirty;
		end else if (hit_write) begin
			dirty_q[hit_way][index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill) begin
			tag_mem[fill_way][index] <= tag;
			line_mem[fill_way][index] <= fill_line;
		end else if (hit_write) begin
			line_mem[hit_way][index][word_sel*32 +: 32] <= merged_word;
		end
	end

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
/*
 * Data cache top level. Chains request decode, array lookup and control,
 * and exposes the core port, the write-buffer port and the read-arbiter port.
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
	parameter int INDEX_W = dcache_cfg_pkg::DEF_INDEX_W,
	parameter int OFFSET_W = dcache_cfg_pkg::DEF_OFFSET_W
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic core_sel,
	input wire dcache_bus_pkg::core_req_t core_req,
	input wire logic core_fence,
	output logic core_ready,
	output logic [31:0] core_rdata,
	output logic wr_req,
	output dcache_bus_pkg::mem_wr_t wr,
	input wire logic wr_ready,
	output logic rd_req,
	output dcache_bus_pkg::mem_rd_t rd,
	input wire logic [31:0] rd_data,
	input wire logic rd_valid,
	input wire logic rd_last
);

	localparam int TAG_W = dcache_cfg_pkg::ADDR_W - INDEX_W - OFFSET_W;

	dcache_bus_pkg::core_req_t cur;
	dcache_bus_pkg::lookup_t look;
	logic [TAG_W-1:0] tag;
	logic [INDEX_W-1:0] index;
	logic [OFFSET_W-1:0] offset;
	logic uncached, started, accept;
	logic hit_write, fill, fill_way, fill_dirty, invalidate_all, walk;
	logic [(8 << OFFSET_W)-1:0] fill_line;
	logic [INDEX_W-1:0] walk_index;

	dcache_req_decode #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_decode (
		.clock, .reset, .sel(core_sel), .req(core_req), .accept,
		.cur, .tag, .index, .offset, .uncached, .started
	);

	dcache_store #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_store (
		.clock, .reset, .tag, .index, .offset, .cur, .hit_write, .fill, .fill_way,
		.fill_line, .fill_dirty, .invalidate_all, .walk_index, .walk, .look
	);

	dcache_ctrl #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_ctrl (
		.clock, .reset, .started, .fence(core_fence), .cur, .tag, .index, .offset,
		.uncached, .look, .wr_ready, .rd_data, .rd_valid, .rd_last,
		.accept, .ready(core_ready), .rdata(core_rdata), .hit_write, .fill, .fill_way,
		.fill_line, .fill_dirty, .invalidate_all, .walk, .walk_index,
		.wr_req, .wr, .rd_req, .rd
	);

endmodule

`default_nettype wire
